//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_ray_state
FILELIST  := sources.f
SIM_ARGS  := +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf obj_dir

//--- common/ray_pkg.sv
package ray_pkg;

  // **************************************************
  // Ray and triangle widths
  // **************************************************

  // Ray ID width, 512 rays in flight.
  localparam int RAY_ID_W = 9;

  // Entries in each per-ray table.
  localparam int NUM_RAYS = 512;

  localparam int TRI_ID_W = 15;  // Closest triangle ID.

  // Triangle table word, triangle ID plus speculative flag.
  localparam int TRI_WORD_W = TRI_ID_W + 1;

  // Bounce count and max_reflect width.
  localparam int COUNT_W = 4;

  // **************************************************
  // Output FIFO
  // **************************************************

  localparam int OUT_FIFO_DEPTH = 4;  // Records toward the shading cache.

  // Free-slot count width of the output FIFO.
  localparam int FIFO_LEFT_W = $clog2(OUT_FIFO_DEPTH + 1);

  // Ray ID, triangle ID, shadow, miss and last flags.
  localparam int OUT_REC_W = RAY_ID_W + TRI_ID_W + 3;

  // **************************************************
  // Count table clear sequencer
  // **************************************************

  typedef enum logic [1:0] {
    CLR_WAIT = 2'd0,  // Held in reset.
    CLR_RUN  = 2'd1,  // Writing zeros.
    CLR_DONE = 2'd2   // Normal operation.
  } clear_state_e;

endpackage

//--- hdl/fifo.sv
`timescale 1ns/1ps

module fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       we,
  input  logic [WIDTH-1:0]           data_in,
  input  logic                       re,
  output logic [WIDTH-1:0]           data_out,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] num_left
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // Entries held.
  logic             push;
  logic             pop;

  // Writes into a full FIFO and reads from an empty one are ignored.
  assign push = we & ~full;
  assign pop  = re & ~empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // **************************************************
  // Pointers and occupancy
  // **************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(DEPTH - 1)) begin
          wr_ptr <= '0;  // Wrap.
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither.
      endcase
    end
  end

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign num_left = CNT_W'(DEPTH) - count;
  assign data_out = mem[rd_ptr];  // Head entry.

endmodule

//--- hdl/ray_state_top.sv
`timescale 1ns/1ps

module ray_state_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [ray_pkg::COUNT_W-1:0]  max_reflect,
  input  logic                         ray_valid,
  input  logic [ray_pkg::RAY_ID_W-1:0] ray_id,
  input  logic                         ray_is_shadow,
  input  logic                         ray_is_miss,
  output logic                         ray_stall,
  input  logic                         tri_wren,
  input  logic [ray_pkg::RAY_ID_W-1:0] tri_wraddr,
  input  logic [ray_pkg::TRI_ID_W-1:0] tri_wrdata,
  input  logic                         tri_is_spec,
  output logic                         out_valid,
  output logic [ray_pkg::RAY_ID_W-1:0] out_ray_id,
  output logic [ray_pkg::TRI_ID_W-1:0] out_tri_id,
  output logic                         out_is_shadow,
  output logic                         out_is_miss,
  output logic                         out_is_last,
  input  logic                         out_stall
);

  logic                         clear_active;
  logic [ray_pkg::RAY_ID_W-1:0] clear_addr;

  // Zeroes the bounce counts after every reset.
  state_clear_ctrl i_state_clear_ctrl (
    .clk          (clk),
    .reset        (reset),
    .clear_active (clear_active),
    .clear_addr   (clear_addr)
  );

  triidstate i_triidstate (
    .clk           (clk),
    .reset         (reset),
    .max_reflect   (max_reflect),
    .ray_valid     (ray_valid),
    .ray_id        (ray_id),
    .ray_is_shadow (ray_is_shadow),
    .ray_is_miss   (ray_is_miss),
    .ray_stall     (ray_stall),
    .tri_wren      (tri_wren),
    .tri_wraddr    (tri_wraddr),
    .tri_wrdata    (tri_wrdata),
    .tri_is_spec   (tri_is_spec),
    .out_valid     (out_valid),
    .out_ray_id    (out_ray_id),
    .out_tri_id    (out_tri_id),
    .out_is_shadow (out_is_shadow),
    .out_is_miss   (out_is_miss),
    .out_is_last   (out_is_last),
    .out_stall     (out_stall),
    .clear_active  (clear_active),  // Holds input off while clearing.
    .clear_addr    (clear_addr)
  );

endmodule

//--- sources.f
common/ray_pkg.sv
hdl/fifo.sv
triidstate/bram_dual_rw.sv
triidstate/state_clear_ctrl.sv
triidstate/triidstate.sv
hdl/ray_state_top.sv
verification/ray_state_sva.sv
verification/tb_ray_state.sv

//--- triidstate/bram_dual_rw.sv
`timescale 1ns/1ps

module bram_dual_rw #(
  parameter int WIDTH = 16
) (
  input  logic                         clk,
  input  logic                         wren,
  input  logic [ray_pkg::RAY_ID_W-1:0] wraddr,
  input  logic [WIDTH-1:0]             wrdata,
  input  logic [ray_pkg::RAY_ID_W-1:0] rdaddr,
  output logic [WIDTH-1:0]             rddata
);

  // One word per ray.
  logic [WIDTH-1:0] mem [ray_pkg::NUM_RAYS];

  // **************************************************
  // Write port
  // **************************************************
  always_ff @(posedge clk) begin
    if (wren) begin
      mem[wraddr] <= wrdata;
    end
  end

  // **************************************************
  // Read port
  // **************************************************

  // Registered read. A write to the same address in the same
  // cycle is not seen, the old word comes back.
  always_ff @(posedge clk) begin
    rddata <= mem[rdaddr];
  end

endmodule

//--- triidstate/state_clear_ctrl.sv
`timescale 1ns/1ps

module state_clear_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         clear_active,
  output logic [ray_pkg::RAY_ID_W-1:0] clear_addr
);

  ray_pkg::clear_state_e state;
  ray_pkg::clear_state_e state_next;
  logic                  last_addr;

  // Final entry of the count table.
  assign last_addr = (int'(clear_addr) == ray_pkg::NUM_RAYS - 1);

  // **************************************************
  // Sequencer FSM
  // **************************************************
  always_comb begin
    state_next = state;
    case (state)
      ray_pkg::CLR_WAIT: begin
        state_next = ray_pkg::CLR_RUN;  // Leave on the first cycle out of reset.
      end
      ray_pkg::CLR_RUN: begin
        if (last_addr) begin
          state_next = ray_pkg::CLR_DONE;
        end
      end
      default: begin
        state_next = ray_pkg::CLR_DONE;  // Stay done.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ray_pkg::CLR_WAIT;
    end else begin
      state <= state_next;
    end
  end

  // Address walk, one entry per cycle while running.
  always_ff @(posedge clk) begin
    if (reset) begin
      clear_addr <= '0;
    end else if (state == ray_pkg::CLR_RUN) begin
      clear_addr <= clear_addr + 1'b1;  // Wraps to zero after the last entry.
    end
  end

  // The datapath stays stalled until the whole table is zero.
  assign clear_active = (state != ray_pkg::CLR_DONE);

endmodule

//--- triidstate/triidstate.sv
`timescale 1ns/1ps

module triidstate (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [ray_pkg::COUNT_W-1:0]  max_reflect,
  // Shadow-or-miss results.
  input  logic                         ray_valid,
  input  logic [ray_pkg::RAY_ID_W-1:0] ray_id,
  input  logic                         ray_is_shadow,
  input  logic                         ray_is_miss,
  output logic                         ray_stall,
  // Closest-triangle writes from intersection.
  input  logic                         tri_wren,
  input  logic [ray_pkg::RAY_ID_W-1:0] tri_wraddr,
  input  logic [ray_pkg::TRI_ID_W-1:0] tri_wrdata,
  input  logic                         tri_is_spec,
  // Records toward the shading cache.
  output logic                         out_valid,
  output logic [ray_pkg::RAY_ID_W-1:0] out_ray_id,
  output logic [ray_pkg::TRI_ID_W-1:0] out_tri_id,
  output logic                         out_is_shadow,
  output logic                         out_is_miss,
  output logic                         out_is_last,
  input  logic                         out_stall,
  // Count table clearing.
  input  logic                         clear_active,
  input  logic [ray_pkg::RAY_ID_W-1:0] clear_addr
);

  logic                            accept;
  logic                            stg_valid;
  logic [ray_pkg::RAY_ID_W-1:0]    stg_ray_id;
  logic                            stg_is_shadow;
  logic                            stg_is_miss;
  logic                            fwd_hit;
  logic [ray_pkg::COUNT_W-1:0]     fwd_count;
  logic [ray_pkg::TRI_ID_W-1:0]    tri_rd_id;
  logic                            tri_rd_spec;
  logic [ray_pkg::COUNT_W-1:0]     state_rd_count;
  logic                            state_wren;
  logic [ray_pkg::RAY_ID_W-1:0]    state_wraddr;
  logic [ray_pkg::COUNT_W-1:0]     state_wrdata;
  logic [ray_pkg::COUNT_W-1:0]     cur_count;
  logic [ray_pkg::COUNT_W-1:0]     new_count;
  logic                            is_last;
  logic [ray_pkg::OUT_REC_W-1:0]   fifo_wr_data;
  logic [ray_pkg::OUT_REC_W-1:0]   fifo_rd_data;
  logic                            fifo_re;
  logic                            fifo_full;
  logic                            fifo_empty;
  logic [ray_pkg::FIFO_LEFT_W-1:0] fifo_num_left;

  // Room is kept for the record in the stage plus the one now accepted.
  assign ray_stall = clear_active | (fifo_num_left < ray_pkg::FIFO_LEFT_W'(2));
  assign accept    = ray_valid & ~ray_stall;

  // **************************************************
  // Single stage, aligned with the RAM read data
  // **************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      stg_valid <= 1'b0;
      fwd_hit   <= 1'b0;
    end else begin
      stg_valid <= accept;
      // Same ray as the record now writing back, so RAM returns a stale count.
      fwd_hit   <= accept & stg_valid & (stg_ray_id == ray_id);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stg_ray_id    <= ray_id;
      stg_is_shadow <= ray_is_shadow;
      stg_is_miss   <= ray_is_miss;
    end
    fwd_count <= new_count;
  end

  // **************************************************
  // Table RAMs
  // **************************************************
  bram_dual_rw #(.WIDTH(ray_pkg::TRI_WORD_W)) tri_bram (
    .clk    (clk),
    .wren   (tri_wren),
    .wraddr (tri_wraddr),
    .wrdata ({tri_wrdata, tri_is_spec}),
    .rdaddr (ray_id),
    .rddata ({tri_rd_id, tri_rd_spec})
  );

  // Clearing owns the write port until the sequencer finishes.
  assign state_wren   = clear_active | stg_valid;
  assign state_wraddr = clear_active ? clear_addr : stg_ray_id;
  assign state_wrdata = clear_active ? '0 : new_count;

  bram_dual_rw #(.WIDTH(ray_pkg::COUNT_W)) state_bram (
    .clk    (clk),
    .wren   (state_wren),
    .wraddr (state_wraddr),
    .wrdata (state_wrdata),
    .rdaddr (ray_id),
    .rddata (state_rd_count)
  );

  // **************************************************
  // Last-event decision and count write-back
  // **************************************************
  assign cur_count = fwd_hit ? fwd_count : state_rd_count;

  assign is_last = (stg_is_miss & ~stg_is_shadow)                // Primary miss.
                 | (stg_is_shadow & (cur_count == max_reflect))  // Out of bounces.
                 | (stg_is_shadow & ~tri_rd_spec);                // Definite hit.

  assign new_count = is_last ? '0 : cur_count + 1'b1;

  // **************************************************
  // Output FIFO
  // **************************************************
  assign fifo_wr_data = {stg_ray_id, tri_rd_id, stg_is_shadow, stg_is_miss, is_last};

  fifo #(
    .WIDTH (ray_pkg::OUT_REC_W),
    .DEPTH (ray_pkg::OUT_FIFO_DEPTH)
  ) scache_fifo (
    .clk      (clk),
    .reset    (reset),
    .we       (stg_valid),
    .data_in  (fifo_wr_data),
    .re       (fifo_re),
    .data_out (fifo_rd_data),
    .full     (fifo_full),
    .empty    (fifo_empty),
    .num_left (fifo_num_left)
  );

  assign out_valid = ~fifo_empty;
  assign fifo_re   = out_valid & ~out_stall;
  assign {out_ray_id, out_tri_id, out_is_shadow, out_is_miss, out_is_last} = fifo_rd_data;

endmodule

//--- verification/ray_state_sva.sv
`timescale 1ns/1ps

module ray_state_sva (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         clear_active,
  input  logic                         stg_valid,
  input  logic                         fifo_full,
  input  logic                         out_valid,
  input  logic                         out_stall,
  input  logic [ray_pkg::RAY_ID_W-1:0] out_ray_id,
  input  logic                         state_wren,
  input  logic [ray_pkg::COUNT_W-1:0]  state_wrdata,
  input  logic [ray_pkg::COUNT_W-1:0]  max_reflect,
  output logic                         failed
);

  logic overflow_hit     = 1'b0;
  logic clear_accept_hit = 1'b0;
  logic hold_broken_hit  = 1'b0;
  logic count_range_hit  = 1'b0;

  // Sticky summary, watched from the testbench.
  assign failed = overflow_hit | clear_accept_hit | hold_broken_hit | count_range_hit;

  // **************************************************
  // Datapath checks
  // **************************************************

  // The stage always finds room in the output FIFO.
  fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
    stg_valid |-> !fifo_full)
    else begin
      overflow_hit = 1'b1;
      $error("stage wrote the output FIFO while it was full");
    end

  // No accepted record reaches the count write-back during clearing.
  no_accept_in_clear: assert property (@(posedge clk) disable iff (reset)
    clear_active |-> !stg_valid)
    else begin
      clear_accept_hit = 1'b1;
      $error("input accepted while the count table was clearing");
    end

  // Head record holds under back-pressure.
  out_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_stall |=> out_valid && $stable(out_ray_id))
    else begin
      hold_broken_hit = 1'b1;
      $error("output record changed while out_stall was high");
    end

  count_in_range: assert property (@(posedge clk) disable iff (reset)
    state_wren |-> state_wrdata <= max_reflect)
    else begin
      count_range_hit = 1'b1;
      $error("bounce count write above max_reflect");
    end

endmodule

bind triidstate ray_state_sva i_ray_state_sva (
  .clk          (clk),
  .reset        (reset),
  .clear_active (clear_active),
  .stg_valid    (stg_valid),
  .fifo_full    (fifo_full),
  .out_valid    (out_valid),
  .out_stall    (out_stall),
  .out_ray_id   (out_ray_id),
  .state_wren   (state_wren),
  .state_wrdata (state_wrdata),
  .max_reflect  (max_reflect),
  .failed       ()
);

//--- verification/tb_ray_state.sv
`timescale 1ns/1ps

module tb_ray_state;

  localparam int NUM_INPUTS = 1200;
  localparam int MAX_CYCLES = 5000;  // Clearing, slowest input rate and margin.
  localparam int RAY_SET    = 8;
  localparam int HOLD_START = 300;   // Long out_stall stretch.
  localparam int HOLD_LEN   = 40;

  logic                         clk;
  logic                         reset;
  logic [ray_pkg::COUNT_W-1:0]  max_reflect;
  logic                         ray_valid;
  logic [ray_pkg::RAY_ID_W-1:0] ray_id;
  logic                         ray_is_shadow;
  logic                         ray_is_miss;
  logic                         ray_stall;
  logic                         tri_wren;
  logic [ray_pkg::RAY_ID_W-1:0] tri_wraddr;
  logic [ray_pkg::TRI_ID_W-1:0] tri_wrdata;
  logic                         tri_is_spec;
  logic                         out_valid;
  logic [ray_pkg::RAY_ID_W-1:0] out_ray_id;
  logic [ray_pkg::TRI_ID_W-1:0] out_tri_id;
  logic                         out_is_shadow;
  logic                         out_is_miss;
  logic                         out_is_last;
  logic                         out_stall;

  logic [31:0]                  rng;
  logic [ray_pkg::TRI_ID_W-1:0] ref_tri [ray_pkg::NUM_RAYS];
  logic                         ref_spec [ray_pkg::NUM_RAYS];
  logic [ray_pkg::COUNT_W-1:0]  ref_count [ray_pkg::NUM_RAYS];
  logic [ray_pkg::RAY_ID_W-1:0] exp_ray_q [$];
  logic [ray_pkg::TRI_ID_W-1:0] exp_tri_q [$];
  logic [2:0]                   exp_flag_q [$];  // Shadow, miss, last.
  int                           cycle_count;
  int                           issued;
  int                           accepted;
  int                           received;
  int                           back_to_back;
  int                           max_hits;
  logic                         saw_backpressure;
  logic                         prev_accept;
  logic [ray_pkg::RAY_ID_W-1:0] prev_ray;

  ray_state_top i_ray_state_top (
    .clk           (clk),
    .reset         (reset),
    .max_reflect   (max_reflect),
    .ray_valid     (ray_valid),
    .ray_id        (ray_id),
    .ray_is_shadow (ray_is_shadow),
    .ray_is_miss   (ray_is_miss),
    .ray_stall     (ray_stall),
    .tri_wren      (tri_wren),
    .tri_wraddr    (tri_wraddr),
    .tri_wrdata    (tri_wrdata),
    .tri_is_spec   (tri_is_spec),
    .out_valid     (out_valid),
    .out_ray_id    (out_ray_id),
    .out_tri_id    (out_tri_id),
    .out_is_shadow (out_is_shadow),
    .out_is_miss   (out_is_miss),
    .out_is_last   (out_is_last),
    .out_stall     (out_stall)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period.

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Eight rays spread over the table.
  function automatic logic [ray_pkg::RAY_ID_W-1:0] ray_of_slot(input logic [2:0] slot);
    return ray_pkg::RAY_ID_W'(int'(slot) * 73);
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  // **************************************************
  // Stimulus for one cycle, driven on the falling edge
  // **************************************************
  task automatic drive_cycle(input int step);
    rng = xorshift32(rng);
    out_stall = (step >= HOLD_START && step < HOLD_START + HOLD_LEN) ? 1'b1
                                                                     : (rng[0] & rng[1]);
    tri_wren    = (rng[3:2] == 2'b00);  // Occasional triangle update.
    tri_wraddr  = ray_of_slot(rng[6:4]);
    tri_wrdata  = rng[22:8];
    tri_is_spec = |rng[24:23];
    if (!ray_valid || accepted == issued) begin
      rng = xorshift32(rng);
      if (issued < NUM_INPUTS && rng[2:0] != 3'd0) begin
        // Otherwise the same ray goes again.
        if (rng[4:3] != 2'b00) begin
          ray_id = ray_of_slot(rng[7:5]);
        end
        ray_is_shadow = |rng[9:8];
        ray_is_miss   = ray_is_shadow ? rng[10] : 1'b1;
        ray_valid     = 1'b1;
        issued++;
      end else begin
        ray_valid = 1'b0;
      end
    end
  endtask

  // **************************************************
  // Reference model and output checks
  // **************************************************
  always @(posedge clk) begin : monitor
    logic [ray_pkg::COUNT_W-1:0]  cnt;
    logic                         last;
    logic [ray_pkg::RAY_ID_W-1:0] exp_ray;
    logic [ray_pkg::TRI_ID_W-1:0] exp_tri;
    logic [2:0]                   exp_flags;
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      stop_on_error($sformatf("Timeout, the run went past %0d cycles", MAX_CYCLES));
    end
    assert (!i_ray_state_top.i_triidstate.i_ray_state_sva.failed)
      else stop_on_error("A bound assertion inside triidstate failed");
    if (!reset && ray_valid && !ray_stall) begin
      cnt  = ref_count[ray_id];
      last = (ray_is_miss && !ray_is_shadow)
          || (ray_is_shadow && cnt == max_reflect)
          || (ray_is_shadow && !ref_spec[ray_id]);
      if (ray_is_shadow && ref_spec[ray_id] && cnt == max_reflect) begin
        max_hits++;
      end
      if (prev_accept && prev_ray == ray_id) begin
        back_to_back++;  // Forwarding case.
      end
      ref_count[ray_id] = last ? '0 : cnt + 1'b1;
      exp_ray_q.push_back(ray_id);
      exp_tri_q.push_back(ref_tri[ray_id]);
      exp_flag_q.push_back({ray_is_shadow, ray_is_miss, last});
      accepted++;
    end
    prev_accept = !reset && ray_valid && !ray_stall;
    prev_ray    = ray_id;
    if (ray_stall && accepted > 0) begin
      saw_backpressure = 1'b1;
    end
    // Seen by lookups from the next cycle on.
    if (tri_wren) begin
      ref_tri[tri_wraddr]  = tri_wrdata;
      ref_spec[tri_wraddr] = tri_is_spec;
    end
    if (!reset && out_valid && !out_stall) begin
      assert (exp_ray_q.size() > 0)
        else stop_on_error("An output record appeared with no accepted input pending");
      exp_ray   = exp_ray_q.pop_front();
      exp_tri   = exp_tri_q.pop_front();
      exp_flags = exp_flag_q.pop_front();
      assert (out_ray_id == exp_ray)
        else stop_on_error($sformatf("ERR out_ray_id got 0x%h expected 0x%h", out_ray_id, exp_ray));
      assert (out_tri_id == exp_tri)
        else stop_on_error($sformatf("ERR out_tri_id got 0x%h expected 0x%h", out_tri_id, exp_tri));
      assert (out_is_shadow == exp_flags[2])
        else stop_on_error($sformatf("ERR out_is_shadow got 0x%h expected 0x%h",
                                     out_is_shadow, exp_flags[2]));
      assert (out_is_miss == exp_flags[1])
        else stop_on_error($sformatf("ERR out_is_miss got 0x%h expected 0x%h",
                                     out_is_miss, exp_flags[1]));
      assert (out_is_last == exp_flags[0])
        else stop_on_error($sformatf("ERR out_is_last got 0x%h expected 0x%h",
                                     out_is_last, exp_flags[0]));
      received++;
    end
  end

  initial begin
    int stall_cycles;
    int step;
    rng = 32'h1fbf_e2c4;
    reset = 1'b1;
    max_reflect = 4'd3;
    ray_valid = 1'b0;
    ray_id = '0;
    ray_is_shadow = 1'b0;
    ray_is_miss = 1'b0;
    tri_wren = 1'b0;
    tri_wraddr = '0;
    tri_wrdata = '0;
    tri_is_spec = 1'b0;
    out_stall = 1'b0;
    cycle_count = 0;
    issued = 0;
    accepted = 0;
    received = 0;
    back_to_back = 0;
    max_hits = 0;
    saw_backpressure = 1'b0;
    prev_accept = 1'b0;
    prev_ray = '0;
    for (int i = 0; i < ray_pkg::NUM_RAYS; i++) begin
      ref_count[i] = '0;
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    // A speculative shadow result waits at the input through the clear.
    ray_valid     = 1'b1;
    ray_id        = ray_of_slot(3'd0);
    ray_is_shadow = 1'b1;
    issued        = 1;
    stall_cycles  = 0;
    while (ray_stall) begin
      assert (!out_valid) else stop_on_error("out_valid rose while the count table was clearing");
      tri_wren    = (stall_cycles < RAY_SET);  // Seed the triangle table meanwhile.
      tri_wraddr  = ray_of_slot(3'(stall_cycles));
      rng         = xorshift32(rng);
      tri_wrdata  = rng[14:0];
      tri_is_spec = 1'b1;
      stall_cycles++;
      @(negedge clk);
    end
    assert (stall_cycles >= ray_pkg::NUM_RAYS)
      else stop_on_error($sformatf("ray_stall dropped after only %0d cycles", stall_cycles));
    tri_wren = 1'b0;
    step = 0;
    while (accepted < NUM_INPUTS) begin
      drive_cycle(step);
      step++;
      @(negedge clk);
    end
    ray_valid = 1'b0;
    tri_wren  = 1'b0;
    out_stall = 1'b0;
    while (received < NUM_INPUTS) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);  // Catch any trailing duplicate.
    assert (saw_backpressure) else stop_on_error("ray_stall never rose under out_stall");
    assert (back_to_back > 0) else stop_on_error("No back-to-back results for one ray");
    assert (max_hits > 0) else stop_on_error("No ray reached max_reflect");
    if (!i_ray_state_top.i_triidstate.i_ray_state_sva.failed) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "a bound assertion failed");
    end
  end

endmodule
